// File: bench/rsp_verify_cases.txt
# case <name> <nai> <single> <base hex> <size> <mask hex> <ignored beats after the run>
# beat <id> <data hex> <resp>
# expect <error> <index> <expected pattern hex> <received pattern hex> <offset> <slverr>

case clean_size4 3 0 11223340 4 ff 0
beat 0 1122334011223340 0
beat 1 1122334111223341 0
beat 2 1122334211223342 0
beat 3 1122334311223343 0
expect 0 0 00000000 00000000 0 0

case mask_size1 1 0 000000a0 1 0f 0
beat 0 00000000a0a0a0a0 0
beat 1 00000000a1a1a1a1 0
expect 0 0 00000000 00000000 0 0

case mask_size2 2 0 0000beef 2 a5 0
beat 0 beefbeefbeefbeef 0
beat 1 bef0bef0bef0bef0 0
beat 2 bef1bef1bef1bef1 0
expect 0 0 00000000 00000000 0 0

# bytes 5 and 6 of beat 2 are wrong, beat 3 is wrong as well
case mismatch_size4 3 0 11223340 4 ff 3
beat 0 1122334011223340 0
beat 1 1122334111223341 0
beat 2 11005a4211223342 0
beat 3 1122334311223300 0
expect 1 2 11223342 11005a42 5 0

case slverr_resp 1 0 00000000 4 ff 0
beat 0 0000000000000000 0
beat 1 0000000100000001 2
expect 0 0 00000000 00000000 0 1

case mismatch_size1 2 0 000001ff 1 ff 0
beat 0 ffffffffffffffff 0
beat 1 00000000ff000000 0
beat 2 0101010101010101 0
expect 1 1 00000200 000000ff 3 0

case single_txn 5 1 cafe0000 4 ff 2
beat 0 cafe0000cafe0000 0
expect 0 0 00000000 00000000 0 0

// File: rsp_verify.f
+incdir+design
design/rsp_verify_pkg.sv
design/rsp_beat_if.sv
design/rsp_capture.sv
design/pattern_gen.sv
design/pattern_compare.sv
design/error_extract.sv
design/rsp_verify_ctrl.sv
design/rsp_verify_top.sv
bench/rsp_verify_tb.sv

// File: Bender.yml
package:
  name: rsp_verify

sources:
  - include_dirs:
      - design
    files:
      - design/rsp_verify_pkg.sv
      - design/rsp_beat_if.sv
      - design/rsp_capture.sv
      - design/pattern_gen.sv
      - design/pattern_compare.sv
      - design/error_extract.sv
      - design/rsp_verify_ctrl.sv
      - design/rsp_verify_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/rsp_verify_tb.sv

// File: bench/rsp_verify_tb.sv
// ============================================================
// testbench for the read-response verifier
// the simulator runs from the project root to find the cases
// filler bytes outside the byte mask are random
// ============================================================
`timescale 1ns/10ps
`include "rsp_verify_params.svh"

module rsp_verify_tb;

  import rsp_verify_pkg::*;

  localparam real CLK_PERIOD    = 8.0;
  localparam int  RESET_CYCLES  = 5;
  localparam int  SETTLE_CYCLES = 8;
  localparam int  CASE_MARGIN   = 20;

  logic          clk;
  logic          reset_n;
  logic          i_enable;
  id_t           i_nai;
  logic          i_single_transaction;
  pattern_t      i_base_pattern;
  pattern_size_t i_pattern_size;
  byte_mask_t    i_byte_mask;
  logic          i_rvalid;
  id_t           i_rid;
  data_t         i_rdata;
  resp_t         i_rresp;
  logic          o_rready;
  logic          o_busy;
  logic          o_record_error;
  logic          o_slverr_received;
  logic          o_error_found;
  id_t           o_error_index;
  pattern_t      o_error_expected_pattern;
  pattern_t      o_error_received_pattern;
  byte_offset_t  o_error_byte_offset;

  // ==========================================================
  // case table with one entry per case and one per beat
  // ==========================================================
  logic [255:0] name_q[$];
  int           nai_q[$];
  int           single_q[$];
  logic [31:0]  base_q[$];
  int           size_q[$];
  logic [7:0]   mask_q[$];
  int           trail_q[$];
  int           first_q[$];
  int           count_q[$];
  int           bid_q[$];
  logic [63:0]  bdata_q[$];
  int           bresp_q[$];
  int           exp_err_q[$];
  int           exp_idx_q[$];
  logic [31:0]  exp_pat_q[$];
  logic [31:0]  rcv_pat_q[$];
  int           exp_off_q[$];
  int           exp_slverr_q[$];

  integer       seed = 32'h1be8_cbf2;
  int           limit_cycles = 0;
  int           record_count;
  logic [255:0] cur_name;

  rsp_verify_top rsp_verify_top_inst
  (
    .clk                      (clk),
    .reset_n                  (reset_n),
    .i_enable                 (i_enable),
    .i_nai                    (i_nai),
    .i_single_transaction     (i_single_transaction),
    .i_base_pattern           (i_base_pattern),
    .i_pattern_size           (i_pattern_size),
    .i_byte_mask              (i_byte_mask),
    .i_rvalid                 (i_rvalid),
    .i_rid                    (i_rid),
    .i_rdata                  (i_rdata),
    .i_rresp                  (i_rresp),
    .o_rready                 (o_rready),
    .o_busy                   (o_busy),
    .o_record_error           (o_record_error),
    .o_slverr_received        (o_slverr_received),
    .o_error_found            (o_error_found),
    .o_error_index            (o_error_index),
    .o_error_expected_pattern (o_error_expected_pattern),
    .o_error_received_pattern (o_error_received_pattern),
    .o_error_byte_offset      (o_error_byte_offset)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // all enabled bytes set to ones
  function automatic data_t mask_bits(input byte_mask_t mask);
    data_t bits;
    for (int k = 0; k < `RSPV_DATA_BYTES; k++)
      bits[8*k +: 8] = mask[k] ? 8'hff : 8'h00;
    return bits;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected)
    else
    begin
      $display("Fail %0s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // inputs change 1 ns after the edge and outputs are sampled at the same time
  task automatic wait_cycle();
    @(posedge clk);
    #1;
    if (o_record_error)
      record_count++;
  endtask

  // ==========================================================
  // cases file reader
  // ==========================================================
  task automatic read_cases();
    integer        fd;
    integer        code;
    logic [255:0]  word;
    logic [255:0]  name;
    logic [2047:0] line;
    int            nai;
    int            single;
    int            size;
    int            trail;
    int            id;
    int            resp;
    int            err;
    int            idx;
    int            off;
    int            slverr;
    logic [31:0]   base;
    logic [31:0]   exp_pat;
    logic [31:0]   rcv_pat;
    logic [7:0]    mask;
    logic [63:0]   data;
    fd = $fopen("bench/rsp_verify_cases.txt", "r");
    if (fd == 0)
      abort_run("cannot open the cases file bench/rsp_verify_cases.txt");
    while ($fscanf(fd, "%s", word) == 1)
    begin
      if (word == "#")
        code = $fgets(line, fd);
      else if (word == "case")
      begin
        code = $fscanf(fd, "%s %d %d %h %d %h %d", name, nai, single, base, size, mask, trail);
        if (code != 7)
          abort_run("a case line in the cases file is malformed");
        name_q.push_back(name);
        nai_q.push_back(nai);
        single_q.push_back(single);
        base_q.push_back(base);
        size_q.push_back(size);
        mask_q.push_back(mask);
        trail_q.push_back(trail);
        first_q.push_back(bid_q.size());
      end
      else if (word == "beat")
      begin
        code = $fscanf(fd, "%d %h %d", id, data, resp);
        if (code != 3)
          abort_run("a beat line in the cases file is malformed");
        bid_q.push_back(id);
        bdata_q.push_back(data);
        bresp_q.push_back(resp);
      end
      else if (word == "expect")
      begin
        code = $fscanf(fd, "%d %d %h %h %d %d", err, idx, exp_pat, rcv_pat, off, slverr);
        if (code != 6 || first_q.size() == 0)
          abort_run("an expect line in the cases file is malformed");
        count_q.push_back(bid_q.size() - first_q[first_q.size() - 1]);
        exp_err_q.push_back(err);
        exp_idx_q.push_back(idx);
        exp_pat_q.push_back(exp_pat);
        rcv_pat_q.push_back(rcv_pat);
        exp_off_q.push_back(off);
        exp_slverr_q.push_back(slverr);
      end
      else
        abort_run("the cases file holds an unknown keyword");
    end
    $fclose(fd);
    if (name_q.size() == 0 || count_q.size() != name_q.size())
      abort_run("the cases file holds no complete test case");
  endtask

  // ==========================================================
  // stimulus and result checks
  // ==========================================================
  task automatic drive_beat(input int b, input byte_mask_t mask);
    data_t fill;
    data_t bits;
    fill     = {$random(seed), $random(seed)};
    bits     = mask_bits(mask);
    i_rvalid = 1'b1;
    i_rid    = id_t'(bid_q[b]);
    i_rdata  = (bdata_q[b] & bits) | (fill & ~bits);
    i_rresp  = resp_t'(bresp_q[b]);
    wait_cycle();
  endtask

  // random beats with a slave error code while ready is low
  task automatic offer_ignored_beats(input int count);
    for (int b = 0; b < count; b++)
    begin
      i_rvalid = 1'b1;
      i_rid    = id_t'($random(seed));
      i_rdata  = {$random(seed), $random(seed)};
      i_rresp  = 2'd2;
      wait_cycle();
    end
    i_rvalid = 1'b0;
    repeat (SETTLE_CYCLES) wait_cycle();
  endtask

  task automatic check_results(input int c);
    check_value("error found", exp_err_q[c], o_error_found);
    check_value("record error pulses", exp_err_q[c], record_count);
    check_value("slverr received", exp_slverr_q[c], o_slverr_received);
    check_value("ready after run", 0, o_rready);
    if (exp_err_q[c] != 0)
    begin
      check_value("error index", exp_idx_q[c], o_error_index);
      check_value("expected pattern", exp_pat_q[c], o_error_expected_pattern);
      check_value("received pattern", rcv_pat_q[c], o_error_received_pattern);
      check_value("byte offset", exp_off_q[c], o_error_byte_offset);
    end
  endtask

  task automatic run_case(input int c);
    cur_name             = name_q[c];
    record_count         = 0;
    i_nai                = id_t'(nai_q[c]);
    i_single_transaction = (single_q[c] != 0);
    i_base_pattern       = base_q[c];
    i_pattern_size       = pattern_size_t'(size_q[c]);
    i_byte_mask          = mask_q[c];
    i_enable             = 1'b1;
    wait_cycle();
    i_enable = 1'b0;
    // busy and ready rise on the edge that takes the enable
    check_value("busy after enable", 1, o_busy);
    check_value("ready after enable", 1, o_rready);
    check_value("error found after enable", 0, o_error_found);
    check_value("slverr after enable", 0, o_slverr_received);
    for (int b = 0; b < count_q[c]; b++)
      drive_beat(first_q[c] + b, mask_q[c]);
    i_rvalid = 1'b0;
    while (o_busy)
      wait_cycle();
    check_results(c);
    if (trail_q[c] > 0)
    begin
      offer_ignored_beats(trail_q[c]);
      check_results(c);
    end
  endtask

  initial
  begin
    int total;
    clk                  = 1'b0;
    reset_n              = 1'b0;
    i_enable             = 1'b0;
    i_nai                = '0;
    i_single_transaction = 1'b0;
    i_base_pattern       = '0;
    i_pattern_size       = 3'd4;
    i_byte_mask          = '1;
    i_rvalid             = 1'b0;
    i_rid                = '0;
    i_rdata              = '0;
    i_rresp              = '0;
    record_count         = 0;
    cur_name             = "reset";
    read_cases();
    total = RESET_CYCLES;
    for (int c = 0; c < name_q.size(); c++)
      total += count_q[c] + trail_q[c] + CASE_MARGIN;
    limit_cycles = total;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;
    for (int c = 0; c < name_q.size(); c++)
      run_case(c);
    $display("TEST PASS");
    $finish;
  end

  // watchdog sized from the beats in the cases file
  initial
  begin
    wait (limit_cycles > 0);
    #(limit_cycles * CLK_PERIOD);
    abort_run($sformatf("timeout, the run did not end within %0d clock cycles", limit_cycles));
  end

endmodule

// File: design/rsp_verify_top.sv
// ============================================================
// read-response verifier with a seven-stage compare pipeline
// there is no back-pressure so the pipeline never stalls
// ============================================================
`timescale 1ns/10ps

module rsp_verify_top
(
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          i_enable,
  input  rsp_verify_pkg::id_t           i_nai,
  input  logic                          i_single_transaction,
  input  rsp_verify_pkg::pattern_t      i_base_pattern,
  input  rsp_verify_pkg::pattern_size_t i_pattern_size,
  input  rsp_verify_pkg::byte_mask_t    i_byte_mask,
  input  logic                          i_rvalid,
  input  rsp_verify_pkg::id_t           i_rid,
  input  rsp_verify_pkg::data_t         i_rdata,
  input  rsp_verify_pkg::resp_t         i_rresp,
  output logic                          o_rready,
  output logic                          o_busy,
  output logic                          o_record_error,
  output logic                          o_slverr_received,
  output logic                          o_error_found,
  output rsp_verify_pkg::id_t           o_error_index,
  output rsp_verify_pkg::pattern_t      o_error_expected_pattern,
  output rsp_verify_pkg::pattern_t      o_error_received_pattern,
  output rsp_verify_pkg::byte_offset_t  o_error_byte_offset
);

  import rsp_verify_pkg::*;

  logic       run_start;
  logic       start_gather;
  logic       beat_done;
  logic       slverr_seen;
  data_t      expected;
  pattern_t   pattern;
  byte_mask_t mismatch;
  data_t      error_data;

  rsp_beat_if cap_beat ();
  rsp_beat_if gen_beat ();

  rsp_capture rsp_capture_inst
  (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_rready    (o_rready),
    .i_run_start (run_start),
    .i_rvalid    (i_rvalid),
    .i_rid       (i_rid),
    .i_rdata     (i_rdata),
    .i_rresp     (i_rresp),
    .o_beat      (cap_beat.src)
  );

  pattern_gen pattern_gen_inst
  (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_rready       (o_rready),
    .i_base_pattern (i_base_pattern),
    .i_pattern_size (i_pattern_size),
    .i_byte_mask    (i_byte_mask),
    .i_beat         (cap_beat.dst),
    .o_beat         (gen_beat.src),
    .o_expected     (expected),
    .o_pattern      (pattern)
  );

  pattern_compare pattern_compare_inst
  (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_rready        (o_rready),
    .i_run_start     (run_start),
    .i_byte_mask     (i_byte_mask),
    .i_beat          (gen_beat.dst),
    .i_expected      (expected),
    .i_pattern       (pattern),
    .o_valid         (beat_done),
    .o_slverr_seen   (slverr_seen),
    .o_error_found   (o_error_found),
    .o_mismatch      (mismatch),
    .o_error_data    (error_data),
    .o_error_index   (o_error_index),
    .o_error_pattern (o_error_expected_pattern)
  );

  error_extract error_extract_inst
  (
    .clk                (clk),
    .reset_n            (reset_n),
    .i_start            (start_gather),
    .i_mismatch         (mismatch),
    .i_error_data       (error_data),
    .i_pattern_size     (i_pattern_size),
    .o_byte_offset      (o_error_byte_offset),
    .o_received_pattern (o_error_received_pattern)
  );

  rsp_verify_ctrl rsp_verify_ctrl_inst
  (
    .clk                  (clk),
    .reset_n              (reset_n),
    .i_enable             (i_enable),
    .i_nai                (i_nai),
    .i_single_transaction (i_single_transaction),
    .i_beat_done          (beat_done),
    .i_error_found        (o_error_found),
    .i_slverr_seen        (slverr_seen),
    .o_run_start          (run_start),
    .o_rready             (o_rready),
    .o_busy               (o_busy),
    .o_start_gather       (start_gather),
    .o_record_error       (o_record_error),
    .o_slverr_received    (o_slverr_received)
  );

endmodule

// File: design/rsp_verify_ctrl.sv
// ============================================================
// run controller with the response counter and status flags
// an NAI of 511 cannot be reached by the 9-bit counter
// ============================================================
`timescale 1ns/10ps

module rsp_verify_ctrl
(
  input  logic                clk,
  input  logic                reset_n,
  input  logic                i_enable,
  input  rsp_verify_pkg::id_t i_nai,
  input  logic                i_single_transaction,
  input  logic                i_beat_done,
  input  logic                i_error_found,
  input  logic                i_slverr_seen,
  output logic                o_run_start,
  output logic                o_rready,
  output logic                o_busy,
  output logic                o_start_gather,
  output logic                o_record_error,
  output logic                o_slverr_received
);

  import rsp_verify_pkg::*;

  ctrl_state_e state;
  ctrl_state_e next_state;
  id_t         nai_q;
  id_t         rsp_count;
  logic        run_done;
  logic        collect_second;

  // a single-transaction run ends on the first response
  assign run_done = i_single_transaction ? (rsp_count != '0) : (rsp_count > nai_q);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      nai_q     <= '0;
      rsp_count <= '0;
    end
    else if (o_run_start)
    begin
      nai_q     <= i_nai;
      rsp_count <= '0;
    end
    else if (i_beat_done)
      rsp_count <= rsp_count + id_t'(1);
  end

  // ==========================================================
  // status towards the response channel and the requester
  // ==========================================================
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      o_rready <= 1'b0;
      o_busy   <= 1'b0;
    end
    else if (o_run_start)
    begin
      o_rready <= 1'b1;
      o_busy   <= 1'b1;
    end
    else
    begin
      if (run_done || state == COMPLETE)
        o_rready <= 1'b0;
      if (state == COMPLETE)
        o_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n || o_run_start)
      o_slverr_received <= 1'b0;
    else if (state == PRECOMPLETE)
      o_slverr_received <= i_slverr_seen;
  end

  // COLLECT_ERROR lasts two cycles so the extraction can settle
  always_ff @(posedge clk)
  begin
    if (!reset_n || state != COLLECT_ERROR)
      collect_second <= 1'b0;
    else
      collect_second <= ~collect_second;
  end

  // ==========================================================
  // state machine
  // ==========================================================
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      state <= IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state     = state;
    o_run_start    = 1'b0;
    o_start_gather = 1'b0;
    o_record_error = 1'b0;
    case (state)
      IDLE:
      begin
        o_run_start = i_enable;
        if (i_enable)
          next_state = START;
      end
      START:         next_state = CHECK_COUNT;
      CHECK_COUNT:
      begin
        if (i_error_found)
          next_state = START_ERROR;
        else if (run_done)
          next_state = PRECOMPLETE;
      end
      START_ERROR:
      begin
        o_start_gather = 1'b1;
        next_state     = COLLECT_ERROR;
      end
      COLLECT_ERROR:
      begin
        if (collect_second)
          next_state = RECORD_ERROR;
      end
      RECORD_ERROR:
      begin
        o_record_error = 1'b1;
        next_state     = PRECOMPLETE;
      end
      PRECOMPLETE:   next_state = COMPLETE;
      COMPLETE:      next_state = IDLE;
      default:       next_state = IDLE;
    endcase
  end

  // a record pulse needs a held error and lasts one cycle
  assert property (@(posedge clk) disable iff (!reset_n)
    o_record_error |-> i_error_found ##1 !o_record_error);

  // busy covers the whole run from START through COMPLETE
  assert property (@(posedge clk) disable iff (!reset_n) (state != IDLE) |-> o_busy);

endmodule

// File: design/error_extract.sv
// ============================================================
// byte offset and received pattern of the first error
// results settle two cycles after i_start
// ============================================================
`timescale 1ns/10ps
`include "rsp_verify_params.svh"

module error_extract
(
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          i_start,
  input  rsp_verify_pkg::byte_mask_t    i_mismatch,
  input  rsp_verify_pkg::data_t         i_error_data,
  input  rsp_verify_pkg::pattern_size_t i_pattern_size,
  output rsp_verify_pkg::byte_offset_t  o_byte_offset,
  output rsp_verify_pkg::pattern_t      o_received_pattern
);

  import rsp_verify_pkg::*;

  logic         gather;
  byte_offset_t first_bit;
  byte_offset_t aligned;
  data_t        shifted;

  // the lowest mismatching byte wins
  always_comb
  begin
    first_bit = '0;
    for (int k = `RSPV_DATA_BYTES - 1; k >= 0; k--)
      if (i_mismatch[k])
        first_bit = byte_offset_t'(k);
  end

  // the received pattern starts at the offset rounded down to the size
  assign aligned = o_byte_offset & ~byte_offset_t'(i_pattern_size - 3'd1);
  assign shifted = i_error_data >> (8 * aligned);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      gather             <= 1'b0;
      o_byte_offset      <= '0;
      o_received_pattern <= '0;
    end
    else
    begin
      gather <= i_start;
      if (i_start)
        o_byte_offset <= first_bit;
      if (gather)
      begin
        case (i_pattern_size)
          3'd1:    o_received_pattern <= {24'h0, shifted[7:0]};
          3'd2:    o_received_pattern <= {16'h0, shifted[15:0]};
          default: o_received_pattern <= shifted[31:0];
        endcase
      end
    end
  end

endmodule

// File: design/pattern_compare.sv
// ============================================================
// pipeline stages 6 and 7 with the masked byte compare
// only the first mismatching beat of a run is held
// ============================================================
`timescale 1ns/10ps
`include "rsp_verify_params.svh"

module pattern_compare
(
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       i_rready,
  input  logic                       i_run_start,
  input  rsp_verify_pkg::byte_mask_t i_byte_mask,
  rsp_beat_if.dst                    i_beat,
  input  rsp_verify_pkg::data_t      i_expected,
  input  rsp_verify_pkg::pattern_t   i_pattern,
  output logic                       o_valid,
  output logic                       o_slverr_seen,
  output logic                       o_error_found,
  output rsp_verify_pkg::byte_mask_t o_mismatch,
  output rsp_verify_pkg::data_t      o_error_data,
  output rsp_verify_pkg::id_t        o_error_index,
  output rsp_verify_pkg::pattern_t   o_error_pattern
);

  import rsp_verify_pkg::*;

  byte_mask_t mismatch;
  logic       capture;

  logic       p6_valid;
  byte_mask_t p6_mismatch;
  data_t      p6_data;
  id_t        p6_id;
  pattern_t   p6_pattern;
  logic       p6_slverr;

  // ==========================================================
  // stage 6 reduces the compare to one bit per enabled byte
  // ==========================================================
  always_comb
  begin
    for (int k = 0; k < `RSPV_DATA_BYTES; k++)
      mismatch[k] = i_byte_mask[k] && (i_beat.data[8*k +: 8] != i_expected[8*k +: 8]);
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n || !i_rready)
    begin
      p6_valid <= 1'b0;
      o_valid  <= 1'b0;
    end
    else
    begin
      p6_valid <= i_beat.valid;
      o_valid  <= p6_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_beat.valid)
    begin
      p6_mismatch <= mismatch;
      p6_data     <= i_beat.data;
      p6_id       <= i_beat.id;
      p6_pattern  <= i_pattern;
      p6_slverr   <= i_beat.slverr;
    end
  end

  // ==========================================================
  // stage 7 freezes the first error until the next run
  // ==========================================================
  assign capture = i_rready && p6_valid && !o_error_found && (|p6_mismatch);

  always_ff @(posedge clk)
  begin
    if (!reset_n || i_run_start)
    begin
      o_error_found   <= 1'b0;
      o_mismatch      <= '0;
      o_error_data    <= '0;
      o_error_index   <= '0;
      o_error_pattern <= '0;
    end
    else if (capture)
    begin
      o_error_found   <= 1'b1;
      o_mismatch      <= p6_mismatch;
      o_error_data    <= p6_data;
      o_error_index   <= p6_id;
      o_error_pattern <= p6_pattern;
    end
  end

  // a slave error anywhere in the run stays visible until the next run
  always_ff @(posedge clk)
  begin
    if (!reset_n || i_run_start)
      o_slverr_seen <= 1'b0;
    else if (i_rready && p6_valid && p6_slverr)
      o_slverr_seen <= 1'b1;
  end

endmodule

// File: design/pattern_gen.sv
// ============================================================
// pipeline stages 3 to 5 that rebuild the expected data word
// the pattern size must be 1, 2 or 4 while beats are in flight
// ============================================================
`timescale 1ns/10ps
`include "rsp_verify_params.svh"

module pattern_gen
(
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          i_rready,
  input  rsp_verify_pkg::pattern_t      i_base_pattern,
  input  rsp_verify_pkg::pattern_size_t i_pattern_size,
  input  rsp_verify_pkg::byte_mask_t    i_byte_mask,
  rsp_beat_if.dst                       i_beat,
  rsp_beat_if.src                       o_beat,
  output rsp_verify_pkg::data_t         o_expected,
  output rsp_verify_pkg::pattern_t      o_pattern
);

  import rsp_verify_pkg::*;

  logic       p3_valid;
  id_t        p3_id;
  data_t      p3_data;
  logic       p3_slverr;
  pattern_t   p3_sum;

  logic       p4_valid;
  id_t        p4_id;
  data_t      p4_data;
  logic       p4_slverr;
  pattern_t   p4_sum;
  pattern_t   p4_trunc;

  logic [1:0] size_mask;
  data_t      expand;

  always_ff @(posedge clk)
  begin
    if (!reset_n || !i_rready)
    begin
      p3_valid     <= 1'b0;
      p4_valid     <= 1'b0;
      o_beat.valid <= 1'b0;
    end
    else
    begin
      p3_valid     <= i_beat.valid;
      p4_valid     <= p3_valid;
      o_beat.valid <= p4_valid;
    end
  end

  // ==========================================================
  // stage 3 adds the index to the base pattern of the set
  // ==========================================================
  always_ff @(posedge clk)
  begin
    if (i_beat.valid)
    begin
      p3_id     <= i_beat.id;
      p3_data   <= i_beat.data;
      p3_slverr <= i_beat.slverr;
      p3_sum    <= i_base_pattern + pattern_t'(i_beat.id);
    end
  end

  // stage 4 keeps only the low pattern-size bytes of the sum
  always_ff @(posedge clk)
  begin
    if (p3_valid)
    begin
      p4_id     <= p3_id;
      p4_data   <= p3_data;
      p4_slverr <= p3_slverr;
      p4_sum    <= p3_sum;
      case (i_pattern_size)
        3'd1:    p4_trunc <= {24'h0, p3_sum[7:0]};
        3'd2:    p4_trunc <= {16'h0, p3_sum[15:0]};
        default: p4_trunc <= p3_sum;
      endcase
    end
  end

  // byte k of the word takes byte (k mod size) of the pattern
  assign size_mask = 2'(i_pattern_size - 3'd1);

  always_comb
  begin
    for (int k = 0; k < `RSPV_DATA_BYTES; k++)
      expand[8*k +: 8] = i_byte_mask[k] ? p4_trunc[8*(k[1:0] & size_mask) +: 8] : 8'h00;
  end

  // ==========================================================
  // stage 5 registers the expanded word
  // ==========================================================
  always_ff @(posedge clk)
  begin
    if (p4_valid)
    begin
      o_beat.id     <= p4_id;
      o_beat.data   <= p4_data;
      o_beat.slverr <= p4_slverr;
      o_expected    <= expand;
      o_pattern     <= p4_sum;
    end
  end

  assert property (@(posedge clk) disable iff (!reset_n)
    (i_beat.valid || p3_valid || p4_valid) |-> i_pattern_size inside {3'd1, 3'd2, 3'd4});

endmodule

// File: design/rsp_capture.sv
// ============================================================
// pipeline stages 1 and 2 of the response channel
// beats offered while i_rready is low are dropped
// ============================================================
`timescale 1ns/10ps

module rsp_capture
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  i_rready,
  input  logic                  i_run_start,
  input  logic                  i_rvalid,
  input  rsp_verify_pkg::id_t   i_rid,
  input  rsp_verify_pkg::data_t i_rdata,
  input  rsp_verify_pkg::resp_t i_rresp,
  rsp_beat_if.src               o_beat
);

  import rsp_verify_pkg::*;

  logic  p1_valid;
  id_t   p1_id;
  data_t p1_data;
  resp_t p1_resp;

  // ==========================================================
  // stage 1 registers the channel
  // ==========================================================
  always_ff @(posedge clk)
  begin
    if (!reset_n || !i_rready)
      p1_valid <= 1'b0;
    else
      p1_valid <= i_rvalid;
  end

  always_ff @(posedge clk)
  begin
    if (i_rready)
    begin
      p1_id   <= i_rid;
      p1_data <= i_rdata;
      p1_resp <= i_rresp;
    end
  end

  // ==========================================================
  // stage 2 forwards the beat and flags a slave error
  // ==========================================================
  always_ff @(posedge clk)
  begin
    if (!reset_n || !i_rready)
      o_beat.valid <= 1'b0;
    else
      o_beat.valid <= p1_valid;
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n || i_run_start)
      o_beat.slverr <= 1'b0;
    else
      o_beat.slverr <= i_rready && p1_valid && (p1_resp == RESP_SLVERR);
  end

  always_ff @(posedge clk)
  begin
    o_beat.id   <= p1_id;
    o_beat.data <= p1_data;
  end

  // an offered beat must carry a defined response code
  assert property (@(posedge clk) disable iff (!reset_n) i_rvalid |-> !$isunknown(i_rresp));

endmodule

// File: design/rsp_beat_if.sv
// ============================================================
// one response beat between pipeline stages
// fields are only meaningful while valid is high
// ============================================================
`timescale 1ns/10ps

interface rsp_beat_if;

  import rsp_verify_pkg::*;

  logic  valid;
  id_t   id;
  data_t data;
  logic  slverr;

  modport src (output valid, output id, output data, output slverr);
  modport dst (input valid, input id, input data, input slverr);

endinterface

// File: design/rsp_verify_pkg.sv
// ============================================================
// types shared by the read-response verifier
// only pattern sizes of 1, 2 and 4 bytes are legal
// ============================================================
`include "rsp_verify_params.svh"

package rsp_verify_pkg;

  typedef logic [`RSPV_DATA_BYTES*8-1:0]         data_t;
  typedef logic [`RSPV_DATA_BYTES-1:0]           byte_mask_t;
  typedef logic [`RSPV_ID_WIDTH-1:0]             id_t;
  typedef logic [`RSPV_PATTERN_WIDTH-1:0]        pattern_t;
  typedef logic [$clog2(`RSPV_DATA_BYTES)-1:0]   byte_offset_t;
  typedef logic [2:0]                            pattern_size_t;
  typedef logic [1:0]                            resp_t;

  // read response code for a slave error
  localparam resp_t RESP_SLVERR = 2'd2;

  typedef enum logic [3:0] {
    IDLE, START, CHECK_COUNT, START_ERROR, COLLECT_ERROR, RECORD_ERROR, PRECOMPLETE, COMPLETE
  } ctrl_state_e;

endpackage

// File: design/rsp_verify_params.svh
// ============================================================
// width settings for the read-response verifier
// the data word is 8 bytes and the pattern is at most 4 bytes
// ============================================================
`ifndef RSP_VERIFY_PARAMS_SVH
`define RSP_VERIFY_PARAMS_SVH

// bytes in one response data word
`define RSPV_DATA_BYTES 8

// the response ID is the address-increment index of the beat
`define RSPV_ID_WIDTH 9

`define RSPV_PATTERN_WIDTH 32

`endif
